// ==== div_subsys.f ====
+incdir+bench
common/div_pkg.sv
rtl/clz32.sv
div_unit/div_operand_prep.sv
div_unit/div_control_fsm.sv
div_unit/div_iter_counter.sv
div_unit/div_datapath.sv
div_unit/div_result_stage.sv
rtl/div_top.sv
bench/div_tb.sv

// ==== bench/div_ref_model.svh ====
// Reference model for RISC-V integer division, included by the divide testbench
// Quotients truncate toward zero and the M extension special cases apply
// Also holds the queue of expected writebacks in issue order
`ifndef DIV_REF_MODEL_SVH
`define DIV_REF_MODEL_SVH

// One expected writeback packed as {id, phys, value}
localparam int ENTRY_W = ID_W + PHYS_W + XLEN;

// Pushed at issue, popped on each ack
logic [ENTRY_W-1:0] expect_q[$];

// Result of one M extension divide op on raw register values
function automatic logic [XLEN-1:0] ref_result(input logic [2:0] fn3,
                                               input logic [XLEN-1:0] a,
                                               input logic [XLEN-1:0] b);
    logic signed [XLEN-1:0] sa;
    logic signed [XLEN-1:0] sb;
    logic [XLEN-1:0]        q;
    logic [XLEN-1:0]        r;
    sa = a;
    sb = b;
    if (b == '0) begin
        // Divide by zero
        q = '1;
        r = a;
    end else if (!fn3[0] && (a == {1'b1, {(XLEN-1){1'b0}}}) && (b == '1)) begin
        // Signed overflow
        q = a;
        r = '0;
    end else if (!fn3[0]) begin
        q = sa / sb;
        r = sa % sb;
    end else begin
        q = a / b;
        r = a % b;
    end
    // Bit 1 picks the remainder
    return fn3[1] ? r : q;
endfunction

`endif

// ==== bench/div_tb.sv ====
// Testbench for the integer divide unit
// Drives random DIV/DIVU/REM/REMU ops from a modelled register file,
// with reissued source pairs, register writes, flushes and random acks,
// and checks every writeback against the reference model
module div_tb import div_pkg::*; ();

    localparam int NUM_OPS = 300;
    // Worst case loop plus ack delay per op
    localparam int MAX_CYCLES = NUM_OPS * 40;

    logic              clk;
    logic              rst;
    logic              issue_valid;
    logic              issue_ready;
    logic [2:0]        issue_fn3;
    logic [XLEN-1:0]   rs1_data;
    logic [XLEN-1:0]   rs2_data;
    logic [PHYS_W-1:0] rs1_phys;
    logic [PHYS_W-1:0] rs2_phys;
    logic [ID_W-1:0]   issue_id;
    logic [PHYS_W-1:0] issue_rd_phys;
    logic              rd_written;
    logic [PHYS_W-1:0] rd_written_phys;
    logic              flush;
    logic              wb_done;
    logic              wb_ack;
    logic [XLEN-1:0]   wb_rd;
    logic [ID_W-1:0]   wb_id;
    logic [PHYS_W-1:0] wb_phys;

    integer            seed;
    int                cycle_count;
    int                issued;
    logic              ack_hold;
    logic [ID_W-1:0]   next_id;
    logic [PHYS_W-1:0] last_rs1;
    logic [PHYS_W-1:0] last_rs2;
    logic [2:0]        last_fn3;
    // Physical register file seen by the issue stage
    logic [XLEN-1:0]   reg_val [0:(1<<PHYS_W)-1];

    `include "div_ref_model.svh"

    div_top u_div_top (
        .clk, .rst, .issue_valid, .issue_ready, .issue_fn3, .rs1_data, .rs2_data,
        .rs1_phys, .rs2_phys, .issue_id, .issue_rd_phys, .rd_written, .rd_written_phys,
        .flush, .wb_done, .wb_ack, .wb_rd, .wb_id, .wb_phys
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // Run limit
    always @(posedge clk) begin
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("CHECKS FAILED");
            $fatal(1, "timeout");
        end else begin
            cycle_count <= cycle_count + 1;
        end
    end

    //////////////////////////////////////////////////
    // Helpers

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "stopped at first failure");
    endtask

    // Full range, zero, minus one, most negative and small magnitudes
    function automatic logic [XLEN-1:0] pick_operand();
        int kind;
        kind = $random(seed) & 7;
        case (kind)
            0: return '0;
            1: return '1;
            2: return {1'b1, {(XLEN-1){1'b0}}};
            3, 4: return $random(seed) % 16;
            5: return $unsigned($random(seed)) >> ($random(seed) & 31);
            default: return $random(seed);
        endcase
    endfunction

    // Front of the queue must sit on the outputs every cycle done is high
    task automatic check_writeback();
        logic [ENTRY_W-1:0] exp;
        assert (expect_q.size() != 0)
        else fail_run("wb_done is high while no divide is outstanding");
        exp = expect_q[0];
        assert ((wb_rd == exp[XLEN-1:0]) && (wb_phys == exp[XLEN +: PHYS_W])
                && (wb_id == exp[XLEN+PHYS_W +: ID_W]))
        else fail_run($sformatf("ERR %0t: writeback id %0d phys %0d rd %h, expected id %0d phys %0d rd %h",
                                $time, wb_id, wb_phys, wb_rd, exp[XLEN+PHYS_W +: ID_W],
                                exp[XLEN +: PHYS_W], exp[XLEN-1:0]));
    endtask

    // Next drive slot, strobes drop and a random ack may go out
    task automatic advance_cycle();
        @(posedge clk);
        #1;
        issue_valid = 1'b0;
        rd_written = 1'b0;
        flush = 1'b0;
        wb_ack = 1'b0;
        if (wb_done) begin
            check_writeback();
            if (!ack_hold && (($random(seed) & 3) != 0)) begin
                wb_ack = 1'b1;
                void'(expect_q.pop_front());
            end
        end
    endtask

    // Another instruction writes a physical register
    task automatic write_reg(input logic [PHYS_W-1:0] phys, input logic [XLEN-1:0] value);
        advance_cycle();
        reg_val[phys] = value;
        rd_written = 1'b1;
        rd_written_phys = phys;
    endtask

    task automatic pulse_flush();
        advance_cycle();
        flush = 1'b1;
    endtask

    task automatic issue_op(input logic [2:0] fn3, input logic [PHYS_W-1:0] rs1p,
                            input logic [PHYS_W-1:0] rs2p);
        logic [PHYS_W-1:0] rdp;
        advance_cycle();
        while (!issue_ready) begin
            advance_cycle();
        end
        rdp = PHYS_W'($random(seed));
        issue_valid = 1'b1;
        issue_fn3 = fn3;
        rs1_data = reg_val[rs1p];
        rs2_data = reg_val[rs2p];
        rs1_phys = rs1p;
        rs2_phys = rs2p;
        issue_id = next_id;
        issue_rd_phys = rdp;
        expect_q.push_back({next_id, rdp, ref_result(fn3, reg_val[rs1p], reg_val[rs2p])});
        next_id = next_id + 1'b1;
        last_rs1 = rs1p;
        last_rs2 = rs2p;
        last_fn3 = fn3;
        issued++;
    endtask

    //////////////////////////////////////////////////
    // Stimulus

    initial begin
        int                kind;
        int                event_kind;
        logic [PHYS_W-1:0] rs1p;
        logic [PHYS_W-1:0] rs2p;
        logic [2:0]        fn3;
        seed = 32'h4e37160d;
        cycle_count = 0;
        issued = 0;
        ack_hold = 1'b0;
        next_id = '0;
        last_rs1 = '0;
        last_rs2 = '0;
        last_fn3 = FN3_DIV;
        rst = 1'b1;
        issue_valid = 1'b0;
        issue_fn3 = FN3_DIV;
        rs1_data = '0;
        rs2_data = '0;
        rs1_phys = '0;
        rs2_phys = '0;
        issue_id = '0;
        issue_rd_phys = '0;
        rd_written = 1'b0;
        rd_written_phys = '0;
        flush = 1'b0;
        wb_ack = 1'b0;
        for (int p = 0; p < (1 << PHYS_W); p++) begin
            reg_val[p] = pick_operand();
        end

        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        assert (issue_ready && !wb_done)
        else fail_run($sformatf("ERR %0t: after reset issue_ready %b wb_done %b",
                                $time, issue_ready, wb_done));

        // Back-pressure, two ops outstanding with ack withheld
        ack_hold = 1'b1;
        issue_op(FN3_DIV, 6'd1, 6'd2);
        issue_op(FN3_DIVU, 6'd3, 6'd4);
        advance_cycle();
        while (!wb_done) begin
            advance_cycle();
        end
        repeat (8) begin
            assert (!issue_ready && (expect_q.size() == 2))
            else fail_run($sformatf("ERR %0t: issue_ready %b with %0d ops outstanding",
                                    $time, issue_ready, expect_q.size()));
            advance_cycle();
        end
        ack_hold = 1'b0;

        // Random mix, often reissuing the last pair as its DIV/REM partner
        // and now and then with the other signedness
        while (issued < NUM_OPS) begin
            kind = $random(seed) & 7;
            if (kind < 3) begin
                event_kind = $random(seed) & 3;
                if (event_kind == 1) begin
                    write_reg(PHYS_W'($random(seed)), pick_operand());
                end else if (event_kind == 2) begin
                    write_reg((($random(seed) & 1) != 0) ? last_rs1 : last_rs2, pick_operand());
                end else if (event_kind == 3) begin
                    pulse_flush();
                end
                issue_op(last_fn3 ^ {1'b0, 1'b1, (kind == 0)}, last_rs1, last_rs2);
            end else begin
                rs1p = PHYS_W'($random(seed));
                rs2p = PHYS_W'($random(seed));
                if (kind >= 6) begin
                    write_reg(rs1p, pick_operand());
                    write_reg(rs2p, pick_operand());
                end
                fn3 = {1'b1, 2'($random(seed))};
                issue_op(fn3, rs1p, rs2p);
            end
        end

        // Drain and make sure nothing extra comes out
        while (expect_q.size() != 0) begin
            advance_cycle();
        end
        repeat (3) advance_cycle();
        assert (!wb_done && issue_ready)
        else fail_run($sformatf("ERR %0t: unit not idle after drain, wb_done %b issue_ready %b",
                                $time, wb_done, issue_ready));
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== rtl/div_top.sv ====
// Top level of the integer divide unit for DIV, DIVU, REM and REMU
// Takes decoded ops with source values on an issue strobe and returns
// results tagged with id and destination on a held done with ack
module div_top import div_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              issue_valid,
    output logic              issue_ready,
    input  logic [2:0]        issue_fn3,
    input  logic [XLEN-1:0]   rs1_data,
    input  logic [XLEN-1:0]   rs2_data,
    input  logic [PHYS_W-1:0] rs1_phys,
    input  logic [PHYS_W-1:0] rs2_phys,
    input  logic [ID_W-1:0]   issue_id,
    input  logic [PHYS_W-1:0] issue_rd_phys,
    input  logic              rd_written,
    input  logic [PHYS_W-1:0] rd_written_phys,
    input  logic              flush,
    output logic              wb_done,
    input  logic              wb_ack,
    output logic [XLEN-1:0]   wb_rd,
    output logic [ID_W-1:0]   wb_id,
    output logic [PHYS_W-1:0] wb_phys
);
    // Prepared operands at issue
    logic [XLEN-1:0]   abs_dividend;
    logic [XLEN-1:0]   abs_divisor;
    logic [CLZ_W-1:0]  dividend_clz;
    logic [CLZ_W-1:0]  divisor_clz;
    logic              divisor_zero;
    logic              negate_result;
    logic              remainder_op;
    logic              reuse;

    // Control
    logic              accept;
    logic              start;
    logic              step;
    logic              last;
    logic              core_done;
    logic              reuse_done;
    logic              pop;

    // Popped op
    logic              pop_remainder_op;
    logic              pop_negate;
    logic              pop_divisor_zero;
    logic [ID_W-1:0]   pop_id;
    logic [PHYS_W-1:0] pop_phys;
    logic [XLEN-1:0]   abs_dividend_held;
    logic [XLEN-1:0]   abs_divisor_held;
    logic [CLZ_W-1:0]  dividend_clz_held;
    logic [CLZ_W-1:0]  divisor_clz_held;

    // Loop results
    logic [XLEN-1:0]   quotient;
    logic [XLEN-1:0]   remainder;

    div_operand_prep u_prep (
        .clk, .rst, .accept, .issue_fn3, .rs1_data, .rs2_data, .rs1_phys, .rs2_phys,
        .issue_rd_phys, .rd_written, .rd_written_phys, .flush,
        .abs_dividend, .abs_divisor, .dividend_clz, .divisor_clz,
        .divisor_zero, .negate_result, .remainder_op, .reuse
    );

    div_control_fsm u_ctrl (
        .clk, .rst, .issue_valid, .abs_dividend, .abs_divisor, .dividend_clz, .divisor_clz,
        .divisor_zero, .negate_result, .remainder_op, .reuse, .issue_id, .issue_rd_phys,
        .last, .wb_done, .wb_ack, .issue_ready, .accept, .start, .step, .core_done,
        .reuse_done, .pop, .pop_remainder_op, .pop_negate, .pop_divisor_zero, .pop_id,
        .pop_phys, .abs_dividend_held, .abs_divisor_held, .dividend_clz_held,
        .divisor_clz_held
    );

    div_iter_counter u_count (
        .clk, .rst, .start,
        .dividend_clz(dividend_clz_held),
        .divisor_clz(divisor_clz_held),
        .divisor_zero(pop_divisor_zero),
        .last
    );

    div_datapath u_loop (
        .clk, .start, .step,
        .abs_dividend(abs_dividend_held),
        .abs_divisor(abs_divisor_held),
        .divisor_clz(divisor_clz_held),
        .dividend_clz(dividend_clz_held),
        .quotient, .remainder
    );

    div_result_stage u_result (
        .clk, .rst, .pop, .pop_remainder_op, .pop_negate, .pop_divisor_zero, .pop_id,
        .pop_phys, .abs_dividend_held, .quotient, .remainder, .core_done, .reuse_done,
        .wb_ack, .wb_done, .wb_rd, .wb_id, .wb_phys
    );

endmodule

// ==== div_unit/div_result_stage.sv ====
// Writeback stage of the divide unit
// Keeps the attributes of the op in the loop, forms the signed result
// and holds done with stable outputs until the writeback ack
module div_result_stage import div_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              pop,
    input  logic              pop_remainder_op,
    input  logic              pop_negate,
    input  logic              pop_divisor_zero,
    input  logic [ID_W-1:0]   pop_id,
    input  logic [PHYS_W-1:0] pop_phys,
    input  logic [XLEN-1:0]   abs_dividend_held,
    input  logic [XLEN-1:0]   quotient,
    input  logic [XLEN-1:0]   remainder,
    input  logic              core_done,
    input  logic              reuse_done,
    input  logic              wb_ack,
    output logic              wb_done,
    output logic [XLEN-1:0]   wb_rd,
    output logic [ID_W-1:0]   wb_id,
    output logic [PHYS_W-1:0] wb_phys
);
    logic            rem_op_q;
    logic            negate_q;
    logic            zero_q;
    logic [XLEN-1:0] dividend_q;
    logic [XLEN-1:0] selected;

    always_ff @(posedge clk) begin
        if (pop) begin
            rem_op_q <= pop_remainder_op;
            negate_q <= pop_negate;
            zero_q <= pop_divisor_zero;
            dividend_q <= abs_dividend_held;
            wb_id <= pop_id;
            wb_phys <= pop_phys;
        end
    end

    // Zero divisor gives all ones or the dividend magnitude
    // Sign is restored by the negate below
    always_comb begin
        if (rem_op_q) begin
            selected = zero_q ? dividend_q : remainder;
        end else begin
            selected = zero_q ? '1 : quotient;
        end
    end

    assign wb_rd = negate_q ? -selected : selected;

    // Held until acked, a completion in the ack cycle keeps it high
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_done <= 1'b0;
        end else begin
            wb_done <= (wb_done & ~wb_ack) | core_done | reuse_done;
        end
    end

    // Loop and attributes stay frozen while a result waits
    assert property (@(posedge clk) disable iff (rst)
        wb_done && !wb_ack |=> wb_done && $stable(wb_rd) && $stable(wb_id)
                               && $stable(wb_phys));

endmodule

// ==== div_unit/div_datapath.sv ====
// Radix-2 shift-subtract loop of the divide unit
// Works on unsigned magnitudes with the divisor aligned to the dividend,
// and keeps quotient and remainder until the next start
module div_datapath import div_pkg::*; (
    input  logic             clk,
    input  logic             start,
    input  logic             step,
    input  logic [XLEN-1:0]  abs_dividend,
    input  logic [XLEN-1:0]  abs_divisor,
    input  logic [CLZ_W-1:0] divisor_clz,
    input  logic [CLZ_W-1:0] dividend_clz,
    output logic [XLEN-1:0]  quotient,
    output logic [XLEN-1:0]  remainder
);
    logic [CLZ_W-1:0] align;
    logic [XLEN-1:0]  divisor_sh;
    logic [XLEN:0]    diff;
    logic             fits;

    //////////////////////////////////////////////////
    // Alignment

    // Moves the divisor top bit under the dividend top bit
    // Wraps when the divisor is larger, but then no step runs
    assign align = divisor_clz - dividend_clz;

    //////////////////////////////////////////////////
    // Compare and subtract

    // Borrow out of the extra bit means the divisor does not fit
    assign diff = {1'b0, remainder} - {1'b0, divisor_sh};
    assign fits = ~diff[XLEN];

    always_ff @(posedge clk) begin
        if (start) begin
            remainder <= abs_dividend;
            quotient <= '0;
            divisor_sh <= abs_divisor << align;
        end else if (step) begin
            if (fits) begin
                remainder <= diff[XLEN-1:0];
            end
            // New quotient bit enters at the bottom
            quotient <= {quotient[XLEN-2:0], fits};
            divisor_sh <= divisor_sh >> 1;
        end
    end

endmodule

// ==== div_unit/div_iter_counter.sv ====
// Iteration counter for the divide loop
// Loads the step count from the leading-zero difference on start and
// flags the final step, or flags at once when no step is needed
module div_iter_counter import div_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  logic [CLZ_W-1:0] dividend_clz,
    input  logic [CLZ_W-1:0] divisor_clz,
    input  logic             divisor_zero,
    output logic             last
);
    logic [ITER_W-1:0] count;
    logic [ITER_W-1:0] load_count;

    // Quotient has at most divisor_clz - dividend_clz + 1 bits
    always_comb begin
        if (divisor_zero || (dividend_clz > divisor_clz)) begin
            load_count = '0;
        end else begin
            load_count = {1'b0, divisor_clz} - {1'b0, dividend_clz} + 1'b1;
        end
    end

    // Loop steps every cycle it runs, so count down while nonzero
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (start) begin
            count <= load_count;
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign last = start ? (load_count == '0) : (count == ITER_W'(1));

endmodule

// ==== div_unit/div_control_fsm.sv ====
// Holding register and loop state machine of the divide unit
// Takes one prepared op on accept and pops it once the loop is free,
// either starting the loop or completing at once from the held result
module div_control_fsm import div_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              issue_valid,
    input  logic [XLEN-1:0]   abs_dividend,
    input  logic [XLEN-1:0]   abs_divisor,
    input  logic [CLZ_W-1:0]  dividend_clz,
    input  logic [CLZ_W-1:0]  divisor_clz,
    input  logic              divisor_zero,
    input  logic              negate_result,
    input  logic              remainder_op,
    input  logic              reuse,
    input  logic [ID_W-1:0]   issue_id,
    input  logic [PHYS_W-1:0] issue_rd_phys,
    input  logic              last,
    input  logic              wb_done,
    input  logic              wb_ack,
    output logic              issue_ready,
    output logic              accept,
    output logic              start,
    output logic              step,
    output logic              core_done,
    output logic              reuse_done,
    output logic              pop,
    output logic              pop_remainder_op,
    output logic              pop_negate,
    output logic              pop_divisor_zero,
    output logic [ID_W-1:0]   pop_id,
    output logic [PHYS_W-1:0] pop_phys,
    output logic [XLEN-1:0]   abs_dividend_held,
    output logic [XLEN-1:0]   abs_divisor_held,
    output logic [CLZ_W-1:0]  dividend_clz_held,
    output logic [CLZ_W-1:0]  divisor_clz_held
);
    div_state_t state;
    div_state_t state_next;
    logic       hold_valid;
    logic       hold_reuse;
    logic       loop_free;

    //////////////////////////////////////////////////
    // Holding register

    // Room when empty, or when the loop is idle and pops it this cycle
    assign issue_ready = ~hold_valid | (state == IDLE);
    assign accept = issue_valid & issue_ready;

    always_ff @(posedge clk) begin
        if (accept) begin
            abs_dividend_held <= abs_dividend;
            abs_divisor_held <= abs_divisor;
            dividend_clz_held <= dividend_clz;
            divisor_clz_held <= divisor_clz;
            pop_divisor_zero <= divisor_zero;
            pop_negate <= negate_result;
            pop_remainder_op <= remainder_op;
            hold_reuse <= reuse;
            pop_id <= issue_id;
            pop_phys <= issue_rd_phys;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hold_valid <= 1'b0;
        end else begin
            hold_valid <= accept | (hold_valid & ~pop);
        end
    end

    //////////////////////////////////////////////////
    // Loop control

    // Loop frees up in the cycle its result is acked
    assign loop_free = (state == IDLE) || (wb_done && wb_ack);
    assign pop = hold_valid & loop_free;
    assign start = pop & ~hold_reuse;
    assign reuse_done = pop & hold_reuse;
    assign step = (state == RUN);

    // A zero step divide finishes in its start cycle
    assign core_done = last & (start | step);

    always_comb begin
        state_next = state;
        if (pop) begin
            if (hold_reuse || last) begin
                state_next = HOLD;
            end else begin
                state_next = RUN;
            end
        end else begin
            case (state)
                RUN: begin
                    if (last) begin
                        state_next = HOLD;
                    end
                end
                HOLD: begin
                    if (wb_done && wb_ack) begin
                        state_next = IDLE;
                    end
                end
                default: begin
                    state_next = state;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Loop registers are never reloaded under a pending result
    // An ack only frees the loop while it holds a finished result
    assert property (@(posedge clk) disable iff (rst)
        start |-> (state == IDLE) || ((state == HOLD) && wb_done && wb_ack));

endmodule

// ==== div_unit/div_operand_prep.sv ====
// Issue side operand preparation for the divide unit
// Produces absolute operands, leading-zero counts and result sign from the
// issue inputs in the issue cycle, and tracks which source pair the last
// divide used so that a matching DIV/REM pair can share one loop
module div_operand_prep import div_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              accept,
    input  logic [2:0]        issue_fn3,
    input  logic [XLEN-1:0]   rs1_data,
    input  logic [XLEN-1:0]   rs2_data,
    input  logic [PHYS_W-1:0] rs1_phys,
    input  logic [PHYS_W-1:0] rs2_phys,
    input  logic [PHYS_W-1:0] issue_rd_phys,
    input  logic              rd_written,
    input  logic [PHYS_W-1:0] rd_written_phys,
    input  logic              flush,
    output logic [XLEN-1:0]   abs_dividend,
    output logic [XLEN-1:0]   abs_divisor,
    output logic [CLZ_W-1:0]  dividend_clz,
    output logic [CLZ_W-1:0]  divisor_clz,
    output logic              divisor_zero,
    output logic              negate_result,
    output logic              remainder_op,
    output logic              reuse
);
    logic              signed_op;
    logic              neg_dividend;
    logic              neg_divisor;
    logic [PHYS_W-1:0] prev_rs1;
    logic [PHYS_W-1:0] prev_rs2;
    logic              prev_signed;
    logic              prev_valid;
    logic              src_overwrite;
    logic              self_overwrite;

    //////////////////////////////////////////////////
    // Sign handling

    assign signed_op = (issue_fn3 == FN3_DIV) || (issue_fn3 == FN3_REM);
    assign remainder_op = (issue_fn3 == FN3_REM) || (issue_fn3 == FN3_REMU);

    assign neg_dividend = signed_op & rs1_data[XLEN-1];
    assign neg_divisor = signed_op & rs2_data[XLEN-1];

    // Most negative value maps onto itself, which is the right magnitude unsigned
    assign abs_dividend = neg_dividend ? -rs1_data : rs1_data;
    assign abs_divisor = neg_divisor ? -rs2_data : rs2_data;

    assign divisor_zero = (rs2_data == '0);

    // Remainder takes the dividend sign
    // Quotient of a zero divisor stays all ones
    assign negate_result = remainder_op ? neg_dividend
                                        : (neg_dividend ^ neg_divisor) & ~divisor_zero;

    clz32 u_dividend_clz (.in(abs_dividend), .count(dividend_clz));
    clz32 u_divisor_clz (.in(abs_divisor), .count(divisor_clz));

    //////////////////////////////////////////////////
    // Result reuse tracking

    always_ff @(posedge clk) begin
        if (accept) begin
            prev_rs1 <= rs1_phys;
            prev_rs2 <= rs2_phys;
            prev_signed <= signed_op;
        end
    end

    // Another instruction retargets a remembered source
    assign src_overwrite = rd_written &&
                           ((rd_written_phys == prev_rs1) || (rd_written_phys == prev_rs2));
    // The divide writes one of its own sources
    assign self_overwrite = (issue_rd_phys == rs1_phys) || (issue_rd_phys == rs2_phys);

    // Set beats clear
    always_ff @(posedge clk) begin
        if (rst) begin
            prev_valid <= 1'b0;
        end else if (accept) begin
            prev_valid <= ~self_overwrite;
        end else if (flush || src_overwrite) begin
            prev_valid <= 1'b0;
        end
    end

    // Signed and unsigned magnitudes of one pair differ
    assign reuse = prev_valid && (rs1_phys == prev_rs1) && (rs2_phys == prev_rs2)
                   && (signed_op == prev_signed);

endmodule

// ==== rtl/clz32.sv ====
// Leading-zero counter for one data word
// Operand prep uses two of these to size the divide loop
// A zero input reports the same count as an input of one
module clz32 import div_pkg::*; (
    input  logic [XLEN-1:0]  in,
    output logic [CLZ_W-1:0] count
);

    // Priority encode of the highest set bit
    // Scanning upward lets the last hit win
    always_comb begin
        count = CLZ_W'(XLEN - 1);
        for (int i = 0; i < XLEN; i++) begin
            if (in[i]) begin
                count = CLZ_W'(XLEN - 1 - i);
            end
        end
    end

endmodule

// ==== common/div_pkg.sv ====
// Shared definitions for the integer divide unit
// Every divide module imports this package for its widths, funct3 codes
// and the loop state encoding
package div_pkg;

    //////////////////////////////////////////////////
    // Widths

    // Data word
    localparam int XLEN = 32;

    // Leading-zero count of one data word
    localparam int CLZ_W = 5;

    // Loop iteration count, one bit wider so a full 32 step run fits
    localparam int ITER_W = CLZ_W + 1;

    // Instruction id tag
    localparam int ID_W = 4;

    // Physical register address
    localparam int PHYS_W = 6;

    //////////////////////////////////////////////////
    // Function codes

    // Bit 0 of funct3 marks unsigned and bit 1 marks remainder
    localparam logic [2:0] FN3_DIV = 3'b100;
    localparam logic [2:0] FN3_DIVU = 3'b101;
    localparam logic [2:0] FN3_REM = 3'b110;
    localparam logic [2:0] FN3_REMU = 3'b111;

    //////////////////////////////////////////////////
    // Loop state

    // IDLE is free, RUN is stepping, HOLD keeps a result until ack
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        RUN = 2'd1,
        HOLD = 2'd2
    } div_state_t;

endpackage
